// ==== logic/ctrl_pkg.sv ====
`default_nettype none

package ctrl_pkg;

    // host register map
    typedef enum logic [1:0] {
        ADDR_SYS_CTRL = 2'd0,
        ADDR_CONTROLS = 2'd1,
        ADDR_STATUS   = 2'd2
    } reg_addr_e;

    localparam int REG_DATA_W = 32;
    localparam int SYS_CTRL_W = 16;

    // system control register bits
    localparam int CTRL_POWERON        = 0;
    localparam int CTRL_ISL_RESET_N    = 1;
    localparam int CTRL_HDMIRX_RESET_N = 2;
    localparam int CTRL_CAPTURE_SEL    = 7;
    localparam int CTRL_AUDMUX_SEL     = 11;
    localparam int CTRL_ADAP_LM        = 14;

    localparam logic [SYS_CTRL_W-1:0] SYS_CTRL_RESET = '0;

    // front panel buttons, released level is high
    localparam int BTN_W = 6;
    localparam logic [BTN_W-1:0] BTN_RESET = '1;

    // status word bits
    localparam int STATUS_SD_DETECT = 0;

endpackage

`default_nettype wire

// ==== logic/video_pkg.sv ====
`default_nettype none

package video_pkg;

    localparam int COLOR_W = 8;

    typedef enum logic [1:0] {
        OSD_BLACK  = 2'd0,
        OSD_BLUE   = 2'd1,
        OSD_YELLOW = 2'd2,
        OSD_WHITE  = 2'd3
    } osd_color_e;

    // osd palette as {r, g, b}
    localparam logic [3*COLOR_W-1:0] OSD_RGB_BLACK  = 24'h000000;
    localparam logic [3*COLOR_W-1:0] OSD_RGB_BLUE   = 24'h0000ff;
    localparam logic [3*COLOR_W-1:0] OSD_RGB_YELLOW = 24'hffff00;
    localparam logic [3*COLOR_W-1:0] OSD_RGB_WHITE  = 24'hffffff;

    // register stages in the video path
    localparam int SELECT_LATENCY  = 1;
    localparam int OVERLAY_LATENCY = 2;

    // led order is {b, g, r}
    localparam logic [2:0] LED_POWER_OFF = 3'b001;

endpackage

`default_nettype wire

// ==== logic/pixel_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// one pixel per clock, no handshake
interface pixel_if import video_pkg::*; ();

    logic [COLOR_W-1:0] r;
    logic [COLOR_W-1:0] g;
    logic [COLOR_W-1:0] b;
    logic               hsync;
    logic               vsync;
    logic               de;

    modport src (output r, g, b, hsync, vsync, de);
    modport snk (input r, g, b, hsync, vsync, de);

endinterface

`default_nettype wire

// ==== logic/ctrl_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// decoded system control fields
interface ctrl_if;

    logic power_on;
    logic isl_reset_n;
    logic hdmirx_reset_n;
    logic capture_sel;
    logic audmux_sel;
    logic adap_lm;

    modport regs (
        output power_on, isl_reset_n, hdmirx_reset_n, capture_sel, audmux_sel, adap_lm
    );

    modport user (
        input power_on, isl_reset_n, hdmirx_reset_n, capture_sel, audmux_sel, adap_lm
    );

endinterface

`default_nettype wire

// ==== logic/sys_ctrl_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module sys_ctrl_regs import ctrl_pkg::*; (
    input  wire logic                  CLK27_i,
    input  wire logic                  po_reset_n,
    input  wire logic                  reg_wr_i,
    input  wire reg_addr_e             reg_addr_i,
    input  wire logic [REG_DATA_W-1:0] reg_wdata_i,
    input  wire logic [BTN_W-1:0]      btn_sync_i,
    input  wire logic                  sd_detect_i,
    output logic      [REG_DATA_W-1:0] reg_rdata_o,
    ctrl_if.regs                       ctrl
);

    logic [SYS_CTRL_W-1:0] sys_ctrl;
    logic [REG_DATA_W-1:0] controls;
    logic [REG_DATA_W-1:0] status;
    logic [REG_DATA_W-1:0] rdata_mux;
    logic                  ctrl_wr;

    assign ctrl_wr = reg_wr_i && (reg_addr_i == ADDR_SYS_CTRL);

    always_ff @(posedge CLK27_i or negedge po_reset_n) begin
        if (!po_reset_n) begin
            sys_ctrl <= SYS_CTRL_RESET;
        end else if (ctrl_wr) begin
            sys_ctrl <= reg_wdata_i[SYS_CTRL_W-1:0];
        end
    end

    assign ctrl.power_on       = sys_ctrl[CTRL_POWERON];
    assign ctrl.isl_reset_n    = sys_ctrl[CTRL_ISL_RESET_N];
    assign ctrl.hdmirx_reset_n = sys_ctrl[CTRL_HDMIRX_RESET_N];
    assign ctrl.capture_sel    = sys_ctrl[CTRL_CAPTURE_SEL];
    assign ctrl.audmux_sel     = sys_ctrl[CTRL_AUDMUX_SEL];
    assign ctrl.adap_lm        = sys_ctrl[CTRL_ADAP_LM];

    assign controls = REG_DATA_W'(btn_sync_i);

    always_comb begin
        status = '0;
        status[STATUS_SD_DETECT] = sd_detect_i;
    end

    always_comb begin
        case (reg_addr_i)
            ADDR_SYS_CTRL: rdata_mux = REG_DATA_W'(sys_ctrl);
            ADDR_CONTROLS: rdata_mux = controls;
            ADDR_STATUS:   rdata_mux = status;
            default:       rdata_mux = '0;
        endcase
    end

    always_ff @(posedge CLK27_i or negedge po_reset_n) begin
        if (!po_reset_n) begin
            reg_rdata_o <= '0;
        end else begin
            reg_rdata_o <= rdata_mux;
        end
    end

    // only a host write may move the control word
    assert property (@(posedge CLK27_i) disable iff (!po_reset_n)
        !ctrl_wr |=> $stable(sys_ctrl));

endmodule

`default_nettype wire

// ==== logic/input_sync.sv ====
`timescale 1ns/1ps
`default_nettype none

module input_sync import ctrl_pkg::*; (
    input  wire logic             CLK27_i,
    input  wire logic             po_reset_n,
    input  wire logic [BTN_W-1:0] btn_i,
    input  wire logic             sd_detect_n_i,
    input  wire logic             resync_strobe_i,
    output logic      [BTN_W-1:0] btn_sync_o,
    output logic                  sd_detect_o,
    output logic                  resync_pulse_o
);

    localparam int SYNC_W = BTN_W + 2;
    // strobe idles low, no card means detect_n high
    localparam logic [SYNC_W-1:0] SYNC_RESET = {1'b0, 1'b1, BTN_RESET};

    logic [SYNC_W-1:0] sync1;
    logic [SYNC_W-1:0] sync2;
    logic              strobe_prev;

    always_ff @(posedge CLK27_i or negedge po_reset_n) begin
        if (!po_reset_n) begin
            sync1          <= SYNC_RESET;
            sync2          <= SYNC_RESET;
            strobe_prev    <= 1'b0;
            resync_pulse_o <= 1'b0;
        end else begin
            sync1          <= {resync_strobe_i, sd_detect_n_i, btn_i};
            sync2          <= sync1;
            strobe_prev    <= sync2[SYNC_W-1];
            // rising edge of the synchronized strobe
            resync_pulse_o <= sync2[SYNC_W-1] & ~strobe_prev;
        end
    end

    assign btn_sync_o  = sync2[BTN_W-1:0];
    assign sd_detect_o = ~sync2[BTN_W];

    assert property (@(posedge CLK27_i) disable iff (!po_reset_n)
        resync_pulse_o |=> !resync_pulse_o);

endmodule

`default_nettype wire

// ==== logic/status_led.sv ====
`timescale 1ns/1ps
`default_nettype none

module status_led import video_pkg::*; #(
    parameter int STRETCH_CYCLES = 2**24 - 1
) (
    input  wire logic CLK27_i,
    input  wire logic po_reset_n,
    input  wire logic resync_pulse_i,
    input  wire logic sd_detect_i,
    ctrl_if.user      ctrl,
    output logic [2:0] led_o
);

    localparam int CNT_W = $clog2(STRETCH_CYCLES + 1);

    logic [CNT_W-1:0] led_cnt;
    logic             led_on;

    always_ff @(posedge CLK27_i or negedge po_reset_n) begin
        if (!po_reset_n) begin
            led_cnt <= '0;
        end else if (resync_pulse_i) begin
            led_cnt <= CNT_W'(STRETCH_CYCLES);
        end else if (led_on) begin
            led_cnt <= led_cnt - 1'b1;
        end
    end

    assign led_on = (led_cnt != '0);

    assign led_o = ctrl.power_on ? {ctrl.adap_lm, sd_detect_i, led_on} : LED_POWER_OFF;

    assert property (@(posedge CLK27_i) disable iff (!po_reset_n)
        led_cnt <= CNT_W'(STRETCH_CYCLES));

endmodule

`default_nettype wire

// ==== logic/source_select.sv ====
`timescale 1ns/1ps
`default_nettype none

module source_select import video_pkg::*; (
    input  wire logic               CLK27_i,
    input  wire logic               po_reset_n,
    input  wire logic [COLOR_W-1:0] isl_r_i,
    input  wire logic [COLOR_W-1:0] isl_g_i,
    input  wire logic [COLOR_W-1:0] isl_b_i,
    input  wire logic               isl_hsync_i,
    input  wire logic               isl_vsync_i,
    input  wire logic               isl_de_i,
    input  wire logic [COLOR_W-1:0] hdmirx_r_i,
    input  wire logic [COLOR_W-1:0] hdmirx_g_i,
    input  wire logic [COLOR_W-1:0] hdmirx_b_i,
    input  wire logic               hdmirx_hsync_i,
    input  wire logic               hdmirx_vsync_i,
    input  wire logic               hdmirx_de_i,
    input  wire logic               pcm_i2s_bck_i,
    input  wire logic               pcm_i2s_ws_i,
    input  wire logic               pcm_i2s_data_i,
    input  wire logic               hdmirx_i2s_bck_i,
    input  wire logic               hdmirx_i2s_ws_i,
    input  wire logic               hdmirx_ap_i,
    ctrl_if.user                    ctrl,
    pixel_if.src                    pix,
    output logic                    i2s_bck_o,
    output logic                    i2s_ws_o,
    output logic                    i2s_data_o
);

    // capture mux, 1 = hdmi receiver
    always_ff @(posedge CLK27_i or negedge po_reset_n) begin
        if (!po_reset_n) begin
            pix.r     <= '0;
            pix.g     <= '0;
            pix.b     <= '0;
            pix.hsync <= 1'b0;
            pix.vsync <= 1'b0;
            pix.de    <= 1'b0;
        end else if (ctrl.capture_sel) begin
            pix.r     <= hdmirx_r_i;
            pix.g     <= hdmirx_g_i;
            pix.b     <= hdmirx_b_i;
            pix.hsync <= hdmirx_hsync_i;
            pix.vsync <= hdmirx_vsync_i;
            pix.de    <= hdmirx_de_i;
        end else begin
            pix.r     <= isl_r_i;
            pix.g     <= isl_g_i;
            pix.b     <= isl_b_i;
            pix.hsync <= isl_hsync_i;
            pix.vsync <= isl_vsync_i;
            pix.de    <= isl_de_i;
        end
    end

    // audio follows the video source without a register
    assign i2s_bck_o  = ctrl.capture_sel ? hdmirx_i2s_bck_i : pcm_i2s_bck_i;
    assign i2s_ws_o   = ctrl.capture_sel ? hdmirx_i2s_ws_i : pcm_i2s_ws_i;
    assign i2s_data_o = ctrl.capture_sel ? hdmirx_ap_i : pcm_i2s_data_i;

endmodule

`default_nettype wire

// ==== logic/osd_overlay.sv ====
`timescale 1ns/1ps
`default_nettype none

module osd_overlay import video_pkg::*; (
    input  wire logic               CLK27_i,
    input  wire logic               po_reset_n,
    input  wire logic               osd_enable_i,
    input  wire osd_color_e         osd_color_i,
    pixel_if.snk                    pix,
    output logic      [COLOR_W-1:0] hdmitx_r_o,
    output logic      [COLOR_W-1:0] hdmitx_g_o,
    output logic      [COLOR_W-1:0] hdmitx_b_o,
    output logic                    hdmitx_hsync_o,
    output logic                    hdmitx_vsync_o,
    output logic                    hdmitx_de_o
);

    logic [3*COLOR_W-1:0] osd_rgb;
    logic [3*COLOR_W-1:0] rgb_q;
    logic                 hsync_q;
    logic                 vsync_q;
    logic                 de_q;

    always_comb begin
        case (osd_color_i)
            OSD_BLACK:  osd_rgb = OSD_RGB_BLACK;
            OSD_BLUE:   osd_rgb = OSD_RGB_BLUE;
            OSD_YELLOW: osd_rgb = OSD_RGB_YELLOW;
            default:    osd_rgb = OSD_RGB_WHITE;
        endcase
    end

    always_ff @(posedge CLK27_i or negedge po_reset_n) begin
        if (!po_reset_n) begin
            rgb_q          <= '0;
            hsync_q        <= 1'b0;
            vsync_q        <= 1'b0;
            de_q           <= 1'b0;
            hdmitx_r_o     <= '0;
            hdmitx_g_o     <= '0;
            hdmitx_b_o     <= '0;
            hdmitx_hsync_o <= 1'b0;
            hdmitx_vsync_o <= 1'b0;
            hdmitx_de_o    <= 1'b0;
        end else begin
            rgb_q   <= osd_enable_i ? osd_rgb : {pix.r, pix.g, pix.b};
            hsync_q <= pix.hsync;
            vsync_q <= pix.vsync;
            de_q    <= pix.de;
            // red lsb held low for the board signal integrity fix
            hdmitx_r_o     <= {rgb_q[3*COLOR_W-1:2*COLOR_W+1], 1'b0};
            hdmitx_g_o     <= rgb_q[2*COLOR_W-1:COLOR_W];
            hdmitx_b_o     <= rgb_q[COLOR_W-1:0];
            hdmitx_hsync_o <= hsync_q;
            hdmitx_vsync_o <= vsync_q;
            hdmitx_de_o    <= de_q;
        end
    end

    assert property (@(posedge CLK27_i) disable iff (!po_reset_n)
        osd_enable_i |-> !$isunknown(osd_color_i));

endmodule

`default_nettype wire

// ==== logic/ossc_lite_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module ossc_lite_top import ctrl_pkg::*, video_pkg::*; #(
    parameter int STRETCH_CYCLES = 2**24 - 1
) (
    input  wire logic                  CLK27_i,
    input  wire logic                  po_reset_n,
    input  wire logic                  reg_wr_i,
    input  wire logic [1:0]            reg_addr_i,
    input  wire logic [REG_DATA_W-1:0] reg_wdata_i,
    output logic      [REG_DATA_W-1:0] reg_rdata_o,
    input  wire logic [COLOR_W-1:0]    isl_r_i,
    input  wire logic [COLOR_W-1:0]    isl_g_i,
    input  wire logic [COLOR_W-1:0]    isl_b_i,
    input  wire logic                  isl_hsync_i,
    input  wire logic                  isl_vsync_i,
    input  wire logic                  isl_de_i,
    input  wire logic [COLOR_W-1:0]    hdmirx_r_i,
    input  wire logic [COLOR_W-1:0]    hdmirx_g_i,
    input  wire logic [COLOR_W-1:0]    hdmirx_b_i,
    input  wire logic                  hdmirx_hsync_i,
    input  wire logic                  hdmirx_vsync_i,
    input  wire logic                  hdmirx_de_i,
    input  wire logic                  pcm_i2s_bck_i,
    input  wire logic                  pcm_i2s_ws_i,
    input  wire logic                  pcm_i2s_data_i,
    input  wire logic                  hdmirx_i2s_bck_i,
    input  wire logic                  hdmirx_i2s_ws_i,
    input  wire logic                  hdmirx_ap_i,
    input  wire logic                  osd_enable_i,
    input  wire logic [1:0]            osd_color_i,
    input  wire logic                  resync_strobe_i,
    input  wire logic [BTN_W-1:0]      btn_i,
    input  wire logic                  sd_detect_n_i,
    output logic      [COLOR_W-1:0]    hdmitx_r_o,
    output logic      [COLOR_W-1:0]    hdmitx_g_o,
    output logic      [COLOR_W-1:0]    hdmitx_b_o,
    output logic                       hdmitx_hsync_o,
    output logic                       hdmitx_vsync_o,
    output logic                       hdmitx_de_o,
    output logic                       hdmitx_i2s_bck_o,
    output logic                       hdmitx_i2s_ws_o,
    output logic                       hdmitx_i2s_data_o,
    output logic      [2:0]            led_o,
    output logic                       audmux_o,
    output logic                       isl_reset_n_o,
    output logic                       hdmirx_reset_n_o
);

    logic [BTN_W-1:0] btn_sync;
    logic             sd_detect;
    logic             resync_pulse;

    pixel_if u_pix ();
    ctrl_if  u_ctrl ();

    sys_ctrl_regs u_sys_ctrl_regs (
        .CLK27_i     (CLK27_i),
        .po_reset_n  (po_reset_n),
        .reg_wr_i    (reg_wr_i),
        .reg_addr_i  (reg_addr_e'(reg_addr_i)),
        .reg_wdata_i (reg_wdata_i),
        .btn_sync_i  (btn_sync),
        .sd_detect_i (sd_detect),
        .reg_rdata_o (reg_rdata_o),
        .ctrl        (u_ctrl.regs)
    );

    input_sync u_input_sync (
        .CLK27_i         (CLK27_i),
        .po_reset_n      (po_reset_n),
        .btn_i           (btn_i),
        .sd_detect_n_i   (sd_detect_n_i),
        .resync_strobe_i (resync_strobe_i),
        .btn_sync_o      (btn_sync),
        .sd_detect_o     (sd_detect),
        .resync_pulse_o  (resync_pulse)
    );

    status_led #(
        .STRETCH_CYCLES (STRETCH_CYCLES)
    ) u_status_led (
        .CLK27_i        (CLK27_i),
        .po_reset_n     (po_reset_n),
        .resync_pulse_i (resync_pulse),
        .sd_detect_i    (sd_detect),
        .ctrl           (u_ctrl.user),
        .led_o          (led_o)
    );

    source_select u_source_select (
        .CLK27_i          (CLK27_i),
        .po_reset_n       (po_reset_n),
        .isl_r_i          (isl_r_i),
        .isl_g_i          (isl_g_i),
        .isl_b_i          (isl_b_i),
        .isl_hsync_i      (isl_hsync_i),
        .isl_vsync_i      (isl_vsync_i),
        .isl_de_i         (isl_de_i),
        .hdmirx_r_i       (hdmirx_r_i),
        .hdmirx_g_i       (hdmirx_g_i),
        .hdmirx_b_i       (hdmirx_b_i),
        .hdmirx_hsync_i   (hdmirx_hsync_i),
        .hdmirx_vsync_i   (hdmirx_vsync_i),
        .hdmirx_de_i      (hdmirx_de_i),
        .pcm_i2s_bck_i    (pcm_i2s_bck_i),
        .pcm_i2s_ws_i     (pcm_i2s_ws_i),
        .pcm_i2s_data_i   (pcm_i2s_data_i),
        .hdmirx_i2s_bck_i (hdmirx_i2s_bck_i),
        .hdmirx_i2s_ws_i  (hdmirx_i2s_ws_i),
        .hdmirx_ap_i      (hdmirx_ap_i),
        .ctrl             (u_ctrl.user),
        .pix              (u_pix.src),
        .i2s_bck_o        (hdmitx_i2s_bck_o),
        .i2s_ws_o         (hdmitx_i2s_ws_o),
        .i2s_data_o       (hdmitx_i2s_data_o)
    );

    osd_overlay u_osd_overlay (
        .CLK27_i        (CLK27_i),
        .po_reset_n     (po_reset_n),
        .osd_enable_i   (osd_enable_i),
        .osd_color_i    (osd_color_e'(osd_color_i)),
        .pix            (u_pix.snk),
        .hdmitx_r_o     (hdmitx_r_o),
        .hdmitx_g_o     (hdmitx_g_o),
        .hdmitx_b_o     (hdmitx_b_o),
        .hdmitx_hsync_o (hdmitx_hsync_o),
        .hdmitx_vsync_o (hdmitx_vsync_o),
        .hdmitx_de_o    (hdmitx_de_o)
    );

    assign isl_reset_n_o    = u_ctrl.isl_reset_n;
    assign hdmirx_reset_n_o = u_ctrl.hdmirx_reset_n;
    // board audio mux select is active low
    assign audmux_o         = ~u_ctrl.audmux_sel;

    // digitizer de reaches the transmitter after both video stages
    assert property (@(posedge CLK27_i) disable iff (!po_reset_n)
        !u_ctrl.capture_sel |-> ##(SELECT_LATENCY + OVERLAY_LATENCY)
        hdmitx_de_o == $past(isl_de_i, SELECT_LATENCY + OVERLAY_LATENCY));

endmodule

`default_nettype wire

// ==== verif/tb_ossc_lite.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_ossc_lite import ctrl_pkg::*; ();

    localparam int CLK_PERIOD = 20;
    localparam int STRETCH    = 40;
    localparam int WAIT_LIMIT = 100;

    logic        CLK27_i = 1'b0;
    logic        po_reset_n;
    logic        reg_wr_i;
    logic [1:0]  reg_addr_i;
    logic [31:0] reg_wdata_i;
    logic [31:0] reg_rdata_o;
    logic [7:0]  isl_r_i, isl_g_i, isl_b_i;
    logic        isl_hsync_i, isl_vsync_i, isl_de_i;
    logic [7:0]  hdmirx_r_i, hdmirx_g_i, hdmirx_b_i;
    logic        hdmirx_hsync_i, hdmirx_vsync_i, hdmirx_de_i;
    logic        pcm_i2s_bck_i, pcm_i2s_ws_i, pcm_i2s_data_i;
    logic        hdmirx_i2s_bck_i, hdmirx_i2s_ws_i, hdmirx_ap_i;
    logic        osd_enable_i;
    logic [1:0]  osd_color_i;
    logic        resync_strobe_i;
    logic [5:0]  btn_i;
    logic        sd_detect_n_i;
    logic [7:0]  hdmitx_r_o, hdmitx_g_o, hdmitx_b_o;
    logic        hdmitx_hsync_o, hdmitx_vsync_o, hdmitx_de_o;
    logic        hdmitx_i2s_bck_o, hdmitx_i2s_ws_o, hdmitx_i2s_data_o;
    logic [2:0]  led_o;
    logic        audmux_o;
    logic        isl_reset_n_o;
    logic        hdmirx_reset_n_o;

    logic [31:0] lfsr = 32'hfa1402c0;
    // what the host has written to the control register
    logic [15:0] ctrl_model = '0;
    logic        osd_random = 1'b0;
    logic        sd_card = 1'b0;
    int          check_cnt = 0;
    int          error_cnt = 0;
    int          timeout_cnt = 0;

    // index 0 is the current cycle
    logic [26:0] isl_hist [4];
    logic [26:0] hdmi_hist [4];
    logic        sel_hist [4];
    logic [2:0]  osd_hist [4];
    int          hist_cnt = 0;

    ossc_lite_top #(
        .STRETCH_CYCLES (STRETCH)
    ) u_ossc_lite_top (.*);

    initial begin
        forever #(CLK_PERIOD / 2) CLK27_i = ~CLK27_i;
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] v);
        int i;
        v = '0;
        for (i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    // pixel words are {r, g, b, hsync, vsync, de}
    function automatic logic [26:0] expected_tx(input logic [26:0] isl_pix,
            input logic [26:0] hdmi_pix, input logic sel, input logic [2:0] osd);
        logic [26:0] pix;
        logic [23:0] rgb;
        pix = sel ? hdmi_pix : isl_pix;
        rgb = pix[26:3];
        if (osd[2]) begin
            case (osd[1:0])
                2'd0:    rgb = 24'h000000;
                2'd1:    rgb = 24'h0000ff;
                2'd2:    rgb = 24'hffff00;
                default: rgb = 24'hffffff;
            endcase
        end
        // red lsb always low on the transmitter side
        rgb[16] = 1'b0;
        return {rgb, pix[2:0]};
    endfunction

    function automatic logic [2:0] expected_led(input logic [15:0] ctrl, input logic sd,
            input logic stretch_on);
        logic [2:0] led;
        if (ctrl[CTRL_POWERON]) begin
            led = {ctrl[CTRL_ADAP_LM], sd, stretch_on};
        end else begin
            led = 3'b001;
        end
        return led;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
            input logic [31:0] actual);
        check_cnt++;
        if (actual !== expected) begin
            error_cnt++;
            $display("CHECK FAILED at %0t: %s expected %h, got %h", $time, name, expected,
                actual);
        end
    endtask

    task automatic next_cycle();
        logic [31:0] v;
        @(negedge CLK27_i);
        draw_bits(27, v);
        {isl_r_i, isl_g_i, isl_b_i, isl_hsync_i, isl_vsync_i, isl_de_i} = v[26:0];
        draw_bits(27, v);
        {hdmirx_r_i, hdmirx_g_i, hdmirx_b_i, hdmirx_hsync_i, hdmirx_vsync_i,
            hdmirx_de_i} = v[26:0];
        draw_bits(6, v);
        {pcm_i2s_bck_i, pcm_i2s_ws_i, pcm_i2s_data_i, hdmirx_i2s_bck_i, hdmirx_i2s_ws_i,
            hdmirx_ap_i} = v[5:0];
        if (osd_random) begin
            draw_bits(3, v);
            osd_enable_i = v[2];
            osd_color_i  = v[1:0];
        end else begin
            osd_enable_i = 1'b0;
            osd_color_i  = 2'd0;
        end
    endtask

    task automatic reg_write(input logic [1:0] addr, input logic [31:0] data);
        next_cycle();
        reg_wr_i    = 1'b1;
        reg_addr_i  = addr;
        reg_wdata_i = data;
        next_cycle();
        reg_wr_i = 1'b0;
        if (addr == ADDR_SYS_CTRL) begin
            ctrl_model = data[15:0];
        end
    endtask

    task automatic reg_read_check(input logic [1:0] addr, input logic [31:0] expected,
            input string name);
        next_cycle();
        reg_addr_i = addr;
        next_cycle();
        check_value(name, expected, reg_rdata_o);
    endtask

    task automatic check_ctrl_outputs();
        check_value("isl_reset_n_o", 32'(ctrl_model[CTRL_ISL_RESET_N]), 32'(isl_reset_n_o));
        check_value("hdmirx_reset_n_o", 32'(ctrl_model[CTRL_HDMIRX_RESET_N]),
            32'(hdmirx_reset_n_o));
        check_value("audmux_o", 32'(!ctrl_model[CTRL_AUDMUX_SEL]), 32'(audmux_o));
        check_value("led_o", 32'(expected_led(ctrl_model, sd_card, 1'b0)), 32'(led_o));
    endtask

    // sampled a quarter period after the falling edge, away from both clock edges
    initial begin : compare
        logic [26:0] tx_word;
        logic [2:0]  i2s_word;
        int          i;
        forever begin
            @(negedge CLK27_i);
            #(CLK_PERIOD / 4);
            if (!po_reset_n) begin
                hist_cnt = 0;
            end else begin
                for (i = 3; i > 0; i--) begin
                    isl_hist[i]  = isl_hist[i-1];
                    hdmi_hist[i] = hdmi_hist[i-1];
                    sel_hist[i]  = sel_hist[i-1];
                    osd_hist[i]  = osd_hist[i-1];
                end
                isl_hist[0]  = {isl_r_i, isl_g_i, isl_b_i, isl_hsync_i, isl_vsync_i, isl_de_i};
                hdmi_hist[0] = {hdmirx_r_i, hdmirx_g_i, hdmirx_b_i, hdmirx_hsync_i,
                    hdmirx_vsync_i, hdmirx_de_i};
                sel_hist[0]  = ctrl_model[CTRL_CAPTURE_SEL];
                osd_hist[0]  = {osd_enable_i, osd_color_i};
                if (hist_cnt < 4) begin
                    hist_cnt++;
                end
                i2s_word = sel_hist[0] ?
                    {hdmirx_i2s_bck_i, hdmirx_i2s_ws_i, hdmirx_ap_i} :
                    {pcm_i2s_bck_i, pcm_i2s_ws_i, pcm_i2s_data_i};
                check_value("hdmitx_i2s", 32'(i2s_word),
                    32'({hdmitx_i2s_bck_o, hdmitx_i2s_ws_o, hdmitx_i2s_data_o}));
                if (hist_cnt == 4) begin
                    tx_word = expected_tx(isl_hist[3], hdmi_hist[3], sel_hist[3], osd_hist[2]);
                    check_value("hdmitx video", 32'(tx_word),
                        32'({hdmitx_r_o, hdmitx_g_o, hdmitx_b_o, hdmitx_hsync_o,
                        hdmitx_vsync_o, hdmitx_de_o}));
                end
            end
        end
    end

    initial begin : stimulus
        logic [31:0] v;
        logic [5:0]  btn_val;
        int          wait_cnt;
        int          on_cnt;
        po_reset_n      = 1'b0;
        reg_wr_i        = 1'b0;
        reg_addr_i      = 2'd0;
        reg_wdata_i     = '0;
        {isl_r_i, isl_g_i, isl_b_i, isl_hsync_i, isl_vsync_i, isl_de_i} = '0;
        {hdmirx_r_i, hdmirx_g_i, hdmirx_b_i, hdmirx_hsync_i, hdmirx_vsync_i,
            hdmirx_de_i} = '0;
        {pcm_i2s_bck_i, pcm_i2s_ws_i, pcm_i2s_data_i} = '0;
        {hdmirx_i2s_bck_i, hdmirx_i2s_ws_i, hdmirx_ap_i} = '0;
        osd_enable_i    = 1'b0;
        osd_color_i     = 2'd0;
        resync_strobe_i = 1'b0;
        btn_i           = '1;
        sd_detect_n_i   = 1'b1;
        repeat (2) next_cycle();
        po_reset_n = 1'b1;

        check_value("hdmitx video after reset", 32'd0, 32'({hdmitx_r_o, hdmitx_g_o,
            hdmitx_b_o, hdmitx_hsync_o, hdmitx_vsync_o, hdmitx_de_o}));
        check_ctrl_outputs();
        reg_read_check(ADDR_SYS_CTRL, 32'd0, "reg_rdata_o sys_ctrl");

        // upper write bits are dropped
        reg_write(ADDR_SYS_CTRL, 32'hdead4807);
        check_ctrl_outputs();
        reg_read_check(ADDR_SYS_CTRL, 32'h00004807, "reg_rdata_o sys_ctrl");
        reg_write(ADDR_STATUS, 32'hffffffff);
        reg_read_check(ADDR_SYS_CTRL, 32'h00004807, "reg_rdata_o sys_ctrl");
        reg_write(ADDR_SYS_CTRL, 32'h00000082);
        check_ctrl_outputs();
        reg_read_check(ADDR_SYS_CTRL, 32'h00000082, "reg_rdata_o sys_ctrl");

        // video from each source, osd off
        reg_write(ADDR_SYS_CTRL, 32'h00004807);
        repeat (40) next_cycle();
        reg_write(ADDR_SYS_CTRL, 32'h00004887);
        repeat (40) next_cycle();

        osd_random = 1'b1;
        repeat (60) next_cycle();
        // adaptive mode off from here on
        reg_write(ADDR_SYS_CTRL, 32'h00000807);
        repeat (60) next_cycle();
        osd_random = 1'b0;

        // buttons and card detect through the synchronizers
        draw_bits(6, v);
        btn_val       = v[5:0];
        btn_i         = btn_val;
        sd_detect_n_i = 1'b0;
        repeat (2) next_cycle();
        sd_card = 1'b1;
        reg_read_check(ADDR_CONTROLS, 32'(btn_val), "reg_rdata_o controls");
        reg_read_check(ADDR_STATUS, 32'd1, "reg_rdata_o status");
        reg_read_check(2'd3, 32'd0, "reg_rdata_o unmapped");
        check_ctrl_outputs();

        resync_strobe_i = 1'b1;
        wait_cnt = 0;
        while (!led_o[0] && wait_cnt < WAIT_LIMIT) begin
            next_cycle();
            wait_cnt++;
        end
        if (!led_o[0]) begin
            $display("resync LED did not light within %0d cycles", WAIT_LIMIT);
            timeout_cnt++;
        end else begin
            resync_strobe_i = 1'b0;
            check_value("led_o", 32'(expected_led(ctrl_model, sd_card, 1'b1)), 32'(led_o));
            on_cnt = 0;
            while (led_o[0] && on_cnt < WAIT_LIMIT) begin
                on_cnt++;
                next_cycle();
            end
            if (led_o[0]) begin
                $display("resync LED still lit after %0d cycles", WAIT_LIMIT);
                timeout_cnt++;
            end
            check_value("led_o[0] lit cycles", STRETCH, on_cnt);
        end
        resync_strobe_i = 1'b0;
        check_ctrl_outputs();
        repeat (4) next_cycle();

        $display("%0d checks, %0d value mismatches, %0d timeouts", check_cnt, error_cnt,
            timeout_cnt);
        if (error_cnt == 0 && timeout_cnt == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
logic/ctrl_pkg.sv
logic/video_pkg.sv
logic/pixel_if.sv
logic/ctrl_if.sv
logic/sys_ctrl_regs.sv
logic/input_sync.sv
logic/status_led.sv
logic/source_select.sv
logic/osd_overlay.sv
logic/ossc_lite_top.sv
verif/tb_ossc_lite.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_ossc_lite -f vlog.f
./obj_dir/Vtb_ossc_lite | tee sim.log

if grep -q "RESULT: FAIL" sim.log; then
    echo "simulation failed"
    exit 1
fi
if ! grep -q "RESULT: PASS" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
echo "simulation passed"
